// File: rtl/pr_queue_pkg.sv
package pr_queue_pkg;

    // Request fields
    localparam int OU_ID_W = 8;
    localparam int GRID_SLOT_W = 24;
    localparam int REQ_W = OU_ID_W + GRID_SLOT_W;

    // Instruction id handed back on writeback
    localparam int ISSUE_ID_W = 3;

    // Queue geometry, depth must stay a power of two
    localparam int QUEUE_DEPTH = 8;
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W = PTR_W + 1;

    // Read channel addresses
    localparam logic [1:0] STATUS_ADDR = 2'b00;
    localparam logic [1:0] PEEK_ADDR = 2'b01;
    localparam logic [1:0] POP_ADDR = 2'b10;

    // Read FSM encoding
    localparam logic [1:0] RD_IDLE = 2'd0;
    localparam logic [1:0] RD_CAPTURE = 2'd1;
    localparam logic [1:0] RD_DATA = 2'd2;

    // One 32-bit read word, seen either as a request or as status
    typedef union packed {
        struct packed {
            logic [OU_ID_W-1:0] ou_id;
            logic [GRID_SLOT_W-1:0] grid_slot;
        } req;
        struct packed {
            logic [REQ_W-COUNT_W-3:0] reserved;
            logic [COUNT_W-1:0] count;
            logic full;
            logic pending;
        } status;
    } pr_read_word_u;

endpackage

// File: rtl/pr_request_fifo.sv
`timescale 1ns/10ps

module pr_request_fifo
    import pr_queue_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  logic [REQ_W-1:0]   push_data,
    input  logic               pop,
    output logic [REQ_W-1:0]   head,
    output logic [COUNT_W-1:0] count,
    output logic               full,
    output logic               empty
);

    logic [REQ_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [COUNT_W-1:0] occupancy;

    // Storage array is written only on push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy holds steady when push and pop land together
    always_ff @(posedge clk) begin
        if (!rst) begin
            occupancy <= '0;
        end else begin
            case ({push, pop})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Oldest entry is always visible at the head
    assign head = mem[rd_ptr];
    assign count = occupancy;
    assign full = (occupancy == COUNT_W'(QUEUE_DEPTH));
    assign empty = (occupancy == '0);

endmodule

// File: rtl/pr_issue_unit.sv
`timescale 1ns/10ps

module pr_issue_unit
    import pr_queue_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_new_request,
    input  logic [ISSUE_ID_W-1:0] issue_id,
    input  logic                  fifo_full,
    input  logic                  wb_ack,
    output logic                  issue_ready,
    output logic                  wb_done,
    output logic [ISSUE_ID_W-1:0] wb_id,
    output logic                  fifo_push
);

    logic wait_ack;
    logic ready_en;

    // Accept only in a cycle where the queue is ready
    assign fifo_push = issue_new_request && issue_ready;

    // Held off for one cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    // Outstanding acknowledge, set wins over clear
    always_ff @(posedge clk) begin
        if (!rst) begin
            wait_ack <= 1'b0;
        end else if (fifo_push) begin
            wait_ack <= 1'b1;
        end else if (wb_ack) begin
            wait_ack <= 1'b0;
        end
    end

    // Id of the request waiting for writeback
    always_ff @(posedge clk) begin
        if (fifo_push) begin
            wb_id <= issue_id;
        end
    end

    // Done stays up for as long as the core has not acknowledged
    assign wb_done = wait_ack;
    assign issue_ready = ready_en && !wait_ack && !fifo_full;

endmodule

// File: rtl/pr_read_ctrl.sv
`timescale 1ns/10ps

module pr_read_ctrl
    import pr_queue_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] s_axi_araddr,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready,
    input  logic       fifo_empty,
    output logic       fifo_pop,
    output logic       capture,
    output logic [1:0] read_sel
);

    logic [1:0] state;
    logic       needs_entry;
    logic       accept;

    // Peek and pop need something in the queue, other reads never wait
    assign needs_entry = (s_axi_araddr == PEEK_ADDR) || (s_axi_araddr == POP_ADDR);
    assign accept = s_axi_arvalid && !(needs_entry && fifo_empty);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (accept) begin
                        state <= RD_CAPTURE;
                    end
                end
                RD_CAPTURE: begin
                    state <= RD_DATA;
                end
                RD_DATA: begin
                    // Hold the data beat until the host takes it
                    if (s_axi_rready) begin
                        state <= RD_IDLE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // Address is latched on the sampling edge
    always_ff @(posedge clk) begin
        if (state == RD_IDLE && accept) begin
            read_sel <= s_axi_araddr;
        end
    end

    // Address handshake happens in the capture cycle
    assign s_axi_arready = (state == RD_CAPTURE);
    assign capture = (state == RD_CAPTURE);

    // Head leaves the queue on the same edge that captures it
    assign fifo_pop = capture && (read_sel == POP_ADDR);

    assign s_axi_rvalid = (state == RD_DATA);

endmodule

// File: rtl/pr_read_formatter.sv
`timescale 1ns/10ps

module pr_read_formatter
    import pr_queue_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               capture,
    input  logic [1:0]         read_sel,
    input  logic [REQ_W-1:0]   head,
    input  logic [COUNT_W-1:0] count,
    input  logic               full,
    input  logic               empty,
    output logic [31:0]        s_axi_rdata
);

    pr_read_word_u word;

    // Pick the view that matches the latched address
    always_comb begin
        word = '0;
        case (read_sel)
            STATUS_ADDR: begin
                word.status.count = count;
                word.status.full = full;
                word.status.pending = !empty;
            end
            PEEK_ADDR, POP_ADDR: begin
                word.req.ou_id = head[REQ_W-1 -: OU_ID_W];
                word.req.grid_slot = head[GRID_SLOT_W-1:0];
            end
            default: begin
                word = '0;
            end
        endcase
    end

    // Data stays put until the next capture
    always_ff @(posedge clk) begin
        if (!rst) begin
            s_axi_rdata <= '0;
        end else if (capture) begin
            s_axi_rdata <= word;
        end
    end

endmodule

// File: rtl/pr_queue_top.sv
`timescale 1ns/10ps

module pr_queue_top
    import pr_queue_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_new_request,
    input  logic [ISSUE_ID_W-1:0]  issue_id,
    input  logic [OU_ID_W-1:0]     req_ou_id,
    input  logic [GRID_SLOT_W-1:0] req_grid_slot,
    output logic                   issue_ready,
    output logic                   wb_done,
    output logic [ISSUE_ID_W-1:0]  wb_id,
    input  logic                   wb_ack,
    input  logic [1:0]             s_axi_araddr,
    input  logic                   s_axi_arvalid,
    output logic                   s_axi_arready,
    output logic [31:0]            s_axi_rdata,
    output logic                   s_axi_rvalid,
    input  logic                   s_axi_rready,
    output logic                   pr_request_pending
);

    logic               fifo_push;
    logic               fifo_pop;
    logic [REQ_W-1:0]   fifo_head;
    logic [COUNT_W-1:0] fifo_count;
    logic               fifo_full;
    logic               fifo_empty;
    logic               capture;
    logic [1:0]         read_sel;

    pr_issue_unit u_issue (
        .clk               (clk),
        .rst               (rst),
        .issue_new_request (issue_new_request),
        .issue_id          (issue_id),
        .fifo_full         (fifo_full),
        .wb_ack            (wb_ack),
        .issue_ready       (issue_ready),
        .wb_done           (wb_done),
        .wb_id             (wb_id),
        .fifo_push         (fifo_push)
    );

    // Request word is ou_id over grid_slot, same order as the read view
    pr_request_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (fifo_push),
        .push_data ({req_ou_id, req_grid_slot}),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .count     (fifo_count),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    pr_read_ctrl u_read_ctrl (
        .clk           (clk),
        .rst           (rst),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .fifo_empty    (fifo_empty),
        .fifo_pop      (fifo_pop),
        .capture       (capture),
        .read_sel      (read_sel)
    );

    pr_read_formatter u_formatter (
        .clk         (clk),
        .rst         (rst),
        .capture     (capture),
        .read_sel    (read_sel),
        .head        (fifo_head),
        .count       (fifo_count),
        .full        (fifo_full),
        .empty       (fifo_empty),
        .s_axi_rdata (s_axi_rdata)
    );

    // Pending goes to the management processor as an interrupt source
    assign pr_request_pending = !fifo_empty;

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Reset releases on a falling edge, away from the active edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

// File: test/tb_pr_queue.sv
`timescale 1ns/10ps

module tb_pr_queue
    import pr_queue_pkg::*;
();

    localparam int CLK_PERIOD_NS = 100;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int RANDOM_OPS = 200;

    logic                   clk;
    logic                   rst;
    logic                   issue_new_request;
    logic [ISSUE_ID_W-1:0]  issue_id;
    logic [OU_ID_W-1:0]     req_ou_id;
    logic [GRID_SLOT_W-1:0] req_grid_slot;
    logic                   issue_ready;
    logic                   wb_done;
    logic [ISSUE_ID_W-1:0]  wb_id;
    logic                   wb_ack;
    logic [1:0]             s_axi_araddr;
    logic                   s_axi_arvalid;
    logic                   s_axi_arready;
    logic [31:0]            s_axi_rdata;
    logic                   s_axi_rvalid;
    logic                   s_axi_rready;
    logic                   pr_request_pending;

    // Reference model state and pending expectations
    logic [REQ_W-1:0]      model_q[$];
    logic [ISSUE_ID_W-1:0] wb_id_q[$];
    logic [31:0]           rdata_q[$];
    logic [31:0]           exp_word;
    logic [ISSUE_ID_W-1:0] exp_id;
    logic [31:0]           last_rdata;
    logic [31:0]           first_peek;
    int                    errors;
    int                    transfers;
    int                    writebacks;
    int                    rand_init;

    tb_clock_gen #(.PERIOD(CLK_PERIOD_NS), .RESET_CYCLES(10)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    pr_queue_top DUT (
        .clk                (clk),
        .rst                (rst),
        .issue_new_request  (issue_new_request),
        .issue_id           (issue_id),
        .req_ou_id          (req_ou_id),
        .req_grid_slot      (req_grid_slot),
        .issue_ready        (issue_ready),
        .wb_done            (wb_done),
        .wb_id              (wb_id),
        .wb_ack             (wb_ack),
        .s_axi_araddr       (s_axi_araddr),
        .s_axi_arvalid      (s_axi_arvalid),
        .s_axi_arready      (s_axi_arready),
        .s_axi_rdata        (s_axi_rdata),
        .s_axi_rvalid       (s_axi_rvalid),
        .s_axi_rready       (s_axi_rready),
        .pr_request_pending (pr_request_pending)
    );

    // Word a read at addr should return, given the model as it stands
    function automatic logic [31:0] expected_read_word(input logic [1:0] addr);
        pr_read_word_u w;
        w = '0;
        case (addr)
            STATUS_ADDR: begin
                w.status.count = COUNT_W'(model_q.size());
                w.status.full = (model_q.size() == QUEUE_DEPTH);
                w.status.pending = (model_q.size() != 0);
            end
            PEEK_ADDR, POP_ADDR: begin
                if (model_q.size() != 0) begin
                    w.req.ou_id = model_q[0][REQ_W-1 -: OU_ID_W];
                    w.req.grid_slot = model_q[0][GRID_SLOT_W-1:0];
                end
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("MISMATCH %s: expected %h, got %h at %0t", name, expected, actual, $time);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    // One request through the issue port, then the writeback acknowledge
    task automatic issue_random_request();
        logic [ISSUE_ID_W-1:0] id;
        logic [REQ_W-1:0]      req;
        int                    gap;
        id = ISSUE_ID_W'($urandom);
        req = $urandom;
        gap = $urandom_range(0, 2);
        while (!issue_ready) begin
            @(negedge clk);
        end
        issue_new_request = 1'b1;
        issue_id = id;
        req_ou_id = req[REQ_W-1 -: OU_ID_W];
        req_grid_slot = req[GRID_SLOT_W-1:0];
        @(negedge clk);
        issue_new_request = 1'b0;
        model_q.push_back(req);
        wb_id_q.push_back(id);
        if (wb_done !== 1'b1) begin
            report_error("wb_done did not rise after an accepted request");
        end
        repeat (gap) begin
            if (issue_ready !== 1'b0) begin
                report_error("issue_ready high while an acknowledge is outstanding");
            end
            @(negedge clk);
        end
        if (issue_ready !== 1'b0) begin
            report_error("issue_ready high while an acknowledge is outstanding");
        end
        wb_ack = 1'b1;
        @(negedge clk);
        wb_ack = 1'b0;
        if (wb_done !== 1'b0) begin
            report_error("wb_done still high after the acknowledge");
        end
        if (issue_ready !== (model_q.size() < QUEUE_DEPTH)) begin
            report_mismatch("issue_ready", (model_q.size() < QUEUE_DEPTH), issue_ready);
        end
    endtask

    // Full AXI-lite read, with a random rready gap on the data beat
    task automatic read_word(input logic [1:0] addr);
        int          gap;
        int          i;
        logic [31:0] held;
        gap = $urandom_range(0, 3);
        s_axi_araddr = addr;
        s_axi_arvalid = 1'b1;
        @(negedge clk);
        while (!s_axi_arready) begin
            @(negedge clk);
        end
        // Handshake and data capture both land on the coming edge
        if ((addr == PEEK_ADDR || addr == POP_ADDR) && model_q.size() == 0) begin
            report_error("arready given for a peek or pop with the queue empty");
        end
        rdata_q.push_back(expected_read_word(addr));
        if (addr == POP_ADDR && model_q.size() != 0) begin
            model_q.delete(0);
        end
        @(negedge clk);
        s_axi_arvalid = 1'b0;
        if (s_axi_arready !== 1'b0) begin
            report_error("arready high for more than one cycle");
        end
        held = s_axi_rdata;
        for (i = 0; i <= gap; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            if (s_axi_rvalid !== 1'b1) begin
                report_error("rvalid low before the data transfer");
            end
            if (s_axi_rdata !== held) begin
                report_mismatch("s_axi_rdata", held, s_axi_rdata);
            end
        end
        s_axi_rready = 1'b1;
        @(negedge clk);
        s_axi_rready = 1'b0;
        if (s_axi_rvalid !== 1'b0) begin
            report_error("rvalid still high after the data transfer");
        end
        if (pr_request_pending !== (model_q.size() != 0)) begin
            report_mismatch("pr_request_pending", (model_q.size() != 0), pr_request_pending);
        end
    endtask

    // Inputs only move on the falling edge, so the rising edge sees them settled
    always @(posedge clk) begin
        if (rst && s_axi_rvalid && s_axi_rready) begin
            transfers++;
            if (rdata_q.size() == 0) begin
                report_error("read data transfer with no read outstanding");
            end else begin
                exp_word = rdata_q.pop_front();
                if (s_axi_rdata !== exp_word) begin
                    report_mismatch("s_axi_rdata", exp_word, s_axi_rdata);
                end
            end
            last_rdata = s_axi_rdata;
        end
        if (rst && wb_done && wb_ack) begin
            writebacks++;
            if (wb_id_q.size() == 0) begin
                report_error("writeback acknowledged with no request accepted");
            end else begin
                exp_id = wb_id_q.pop_front();
                if (wb_id !== exp_id) begin
                    report_mismatch("wb_id", exp_id, wb_id);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
        $display("Timeout after %0d cycles, %0d errors so far", TIMEOUT_CYCLES, errors);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int op;
        rand_init = $urandom(32'h5c95);
        issue_new_request = 1'b0;
        issue_id = '0;
        req_ou_id = '0;
        req_grid_slot = '0;
        wb_ack = 1'b0;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        errors = 0;
        transfers = 0;
        writebacks = 0;

        wait (rst === 1'b1);
        if ({issue_ready, wb_done, s_axi_arready, s_axi_rvalid, pr_request_pending}
                !== 5'b0) begin
            report_error("outputs not low right after reset");
        end
        @(negedge clk);
        if (issue_ready !== 1'b1) begin
            report_error("issue_ready not high one cycle after reset");
        end

        // Empty queue status and the unused address
        read_word(STATUS_ADDR);
        read_word(2'b11);

        // Two peeks in a row must agree
        repeat (3) issue_random_request();
        read_word(PEEK_ADDR);
        first_peek = last_rdata;
        read_word(PEEK_ADDR);
        if (last_rdata !== first_peek) begin
            report_mismatch("s_axi_rdata", first_peek, last_rdata);
        end
        read_word(STATUS_ADDR);
        repeat (3) read_word(POP_ADDR);

        // Fill to depth, issue stays blocked after the last acknowledge
        repeat (QUEUE_DEPTH) issue_random_request();
        repeat (5) begin
            if (issue_ready !== 1'b0) begin
                report_error("issue_ready high with the queue full");
            end
            @(negedge clk);
        end
        read_word(STATUS_ADDR);
        read_word(PEEK_ADDR);
        repeat (QUEUE_DEPTH) begin
            read_word(POP_ADDR);
            read_word(STATUS_ADDR);
        end

        // Pop on an empty queue waits for the next push
        fork
            read_word(POP_ADDR);
            begin
                repeat (6) @(negedge clk);
                issue_random_request();
            end
        join

        // Random mix of issues and reads
        repeat (RANDOM_OPS) begin
            op = $urandom_range(0, 3);
            if (op < 2 && model_q.size() < QUEUE_DEPTH) begin
                issue_random_request();
            end else if (model_q.size() == 0) begin
                read_word($urandom_range(0, 1) ? 2'b11 : STATUS_ADDR);
            end else begin
                read_word(2'($urandom_range(0, 3)));
            end
        end

        repeat (2) @(negedge clk);
        if (rdata_q.size() != 0 || wb_id_q.size() != 0) begin
            report_error("reads or writebacks left without a response");
        end
        $display("Done: %0d read transfers, %0d writebacks, %0d errors",
                 transfers, writebacks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/pr_queue_pkg.sv
rtl/pr_request_fifo.sv
rtl/pr_issue_unit.sv
rtl/pr_read_ctrl.sv
rtl/pr_read_formatter.sv
rtl/pr_queue_top.sv
test/tb_clock_gen.sv
test/tb_pr_queue.sv
